// File: hdl/heapPkg.sv
/*
  Shared sizes, opcodes and status codes for the array heap.
  Modules pull these in with a wildcard import in their header.
*/
package heapPkg;

  // sizes --------------------
  localparam int arrayBits   = 3;                 // bits of an array number
  localparam int arrayCount  = 8;                 // number of arrays held
  localparam int indexBits   = 3;                 // bits of an element index
  localparam int arrayLength = 8;                 // elements per array
  localparam int sizeBits    = indexBits + 1;     // a full array needs the extra bit
  localparam int dataBits    = 16;                // width of one element

  // opcodes on the action input
  // gaps in the numbering are unused codes
  typedef enum logic [4:0] {
    idle     = 5'd0,                              // response holds
    write    = 5'd2,                              // store in at index and grow if past end
    read     = 5'd3,                              // element at index
    size     = 5'd4,                              // current size of array
    inc      = 5'd5,                              // grow by one if room
    dec      = 5'd6,                              // shrink by one if not empty
    push     = 5'd14,                             // append in
    pop      = 5'd15,                             // remove and return last
    resize   = 5'd17,                             // set size to in
    alloc    = 5'd18,                             // hand out an array with its number on out
    free     = 5'd19,                             // give an array back
    add      = 5'd20,                             // element += in and return new value
    addAfter = 5'd21,                             // element += in and return old value
    subtract = 5'd22,                             // element -= in and return new value
    subAfter = 5'd23,                             // element -= in and return old value
    orOp     = 5'd28,                             // element |= in
    xorOp    = 5'd29,                             // element ^= in
    andOp    = 5'd30                              // element &= in
  } heapAction_t;

  // status on the error output --------------------
  typedef enum logic [2:0] {
    none         = 3'd0,                          // action done
    notAllocated = 3'd1,                          // never allocated or already freed
    outOfBounds  = 3'd2,                          // index not below size
    full         = 3'd3,                          // push or inc with no room
    empty        = 3'd4,                          // pop or dec with nothing left
    tooLarge     = 3'd5,                          // resize past arrayLength
    outOfMemory  = 3'd6                           // alloc with every array in use
  } heapError_t;

endpackage

// File: hdl/arrayAllocator.sv
/*
  Decides alloc and free for the array heap. Freed arrays sit on a stack
  and are reused newest first, untouched arrays follow in order.
  Outputs are combinational on the current action, state moves on the edge.
*/
`timescale 1ns/1ps

module arrayAllocator import heapPkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  heapAction_t          action,
  input  logic [arrayBits-1:0] array,
  output logic                 arrayAllocated,  // flag of the addressed array
  output logic                 grant,           // alloc succeeds this cycle
  output logic [arrayBits-1:0] grantArray,      // array being handed out
  output heapError_t           allocError       // only means something for alloc/free
);

  logic [arrayCount-1:0] allocFlags;              // one bit per live array
  logic [arrayBits-1:0]  freeStack [arrayCount];  // numbers of freed arrays
  logic [arrayBits:0]    stackDepth;              // 0 .. arrayCount
  logic [arrayBits:0]    nextFresh;               // lowest never-used array
  logic [arrayBits-1:0]  topIndex;                // slot of newest freed array
  logic                  stackAvailable;
  logic                  freshAvailable;

  // decisions --------------------
  assign arrayAllocated = allocFlags[array];
  assign stackAvailable = stackDepth != '0;
  assign freshAvailable = nextFresh < arrayCount;
  assign topIndex       = stackDepth[arrayBits-1:0] - 1'b1;  // wraps right at full depth

  assign grant      = (action == alloc) && (stackAvailable || freshAvailable);
  assign grantArray = stackAvailable ? freeStack[topIndex]   // reuse before fresh
                                     : nextFresh[arrayBits-1:0];

  always_comb begin
    allocError = none;
    if (action == alloc && !grant) begin
      allocError = outOfMemory;
    end else if (action == free && !arrayAllocated) begin
      allocError = notAllocated;                  // also catches a second free
    end
  end

  // state --------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      allocFlags <= '0;
      stackDepth <= '0;
      nextFresh  <= '0;
    end else if (grant) begin
      allocFlags[grantArray] <= 1'b1;
      if (stackAvailable) begin
        stackDepth <= stackDepth - 1'b1;          // pop the stack
      end else begin
        nextFresh <= nextFresh + 1'b1;            // take next untouched
      end
    end else if (action == free && arrayAllocated) begin
      allocFlags[array] <= 1'b0;
      stackDepth        <= stackDepth + 1'b1;
    end
  end

  // stack slots themselves
  always_ff @(posedge clock) begin
    if (action == free && arrayAllocated) begin
      freeStack[stackDepth[arrayBits-1:0]] <= array;  // depth below count here
    end
  end

  // a freed array is only ever pushed once, so the stack cannot overrun
  stackBound: assert property (
    @(posedge clock) disable iff (reset) stackDepth <= arrayCount
  );

endmodule

// File: hdl/arrayStore.sv
/*
  Element memory and size table of the array heap.
  Checks every non alloc/free action, applies it, and registers out and
  error on the same edge. Alloc and free status comes from the allocator.
*/
`timescale 1ns/1ps

module arrayStore import heapPkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  heapAction_t          action,
  input  logic [arrayBits-1:0] array,
  input  logic [indexBits-1:0] index,
  input  logic [dataBits-1:0]  in,
  input  logic                 arrayAllocated,
  input  logic                 grant,
  input  logic [arrayBits-1:0] grantArray,
  input  heapError_t           allocError,
  output logic [dataBits-1:0]  out,
  output heapError_t           error
);

  logic [dataBits-1:0]  memory [arrayCount][arrayLength];  // fixed block per array
  logic [sizeBits-1:0]  sizes  [arrayCount];               // live elements per array

  logic [sizeBits-1:0]  curSize;                  // size of addressed array
  logic [dataBits-1:0]  element;                  // element at index
  logic [indexBits-1:0] lastIndex;                // slot pop reads
  logic                 inBounds;
  logic                 isFull;
  logic                 isEmpty;
  logic                 isElementOp;
  logic [dataBits-1:0]  opResult;                 // read-modify-write value
  heapError_t           nextError;
  logic                 memWrite;
  logic [indexBits-1:0] memIndex;
  logic [dataBits-1:0]  memData;

  // addressed array --------------------
  assign curSize   = sizes[array];
  assign element   = memory[array][index];
  assign lastIndex = curSize[indexBits-1:0] - 1'b1;
  assign inBounds  = sizeBits'(index) < curSize;
  assign isFull    = curSize == sizeBits'(arrayLength);
  assign isEmpty   = curSize == '0;
  assign isElementOp = action inside {add, addAfter, subtract, subAfter, orOp, xorOp, andOp};

  always_comb begin
    unique case (action)
      add, addAfter:      opResult = element + in;  // wraps at dataBits
      subtract, subAfter: opResult = element - in;
      orOp:               opResult = element | in;
      xorOp:              opResult = element ^ in;
      andOp:              opResult = element & in;
      default:            opResult = element;
    endcase
  end

  // status of the current action
  always_comb begin
    nextError = none;
    if (action == alloc || action == free) begin
      nextError = allocError;                     // allocator owns these
    end else if (action != idle && !arrayAllocated) begin
      nextError = notAllocated;
    end else begin
      case (action)
        read:      if (!inBounds) nextError = outOfBounds;
        inc, push: if (isFull)    nextError = full;
        dec, pop:  if (isEmpty)   nextError = empty;
        resize:    if (in > dataBits'(arrayLength)) nextError = tooLarge;
        default:   if (isElementOp && !inBounds) nextError = outOfBounds;
      endcase
    end
  end

  // element memory --------------------
  always_comb begin
    memWrite = 1'b0;
    memIndex = index;
    memData  = in;
    if (nextError == none) begin
      if (action == write) begin
        memWrite = 1'b1;
      end else if (action == push) begin
        memWrite = 1'b1;
        memIndex = curSize[indexBits-1:0];        // append slot
      end else if (isElementOp) begin
        memWrite = 1'b1;
        memData  = opResult;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (memWrite) begin
      memory[array][memIndex] <= memData;
    end
  end

  // sizes and response --------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      out   <= '0;
      error <= none;
      for (int i = 0; i < arrayCount; i++) begin
        sizes[i] <= '0;
      end
    end else begin
      if (action != idle) error <= nextError;     // idle holds the old status
      if (grant) begin
        sizes[grantArray] <= '0;                  // new array starts empty
        out               <= dataBits'(grantArray);
      end else if (nextError == none) begin
        case (action)
          write: begin
            out <= in;
            if (!inBounds) sizes[array] <= sizeBits'(index) + 1'b1;  // grew past end
          end
          read:                          out <= element;
          size:                          out <= dataBits'(curSize);
          inc:                           sizes[array] <= curSize + 1'b1;
          dec:                           sizes[array] <= curSize - 1'b1;
          push:                          sizes[array] <= curSize + 1'b1;
          pop: begin
            out          <= memory[array][lastIndex];
            sizes[array] <= curSize - 1'b1;
          end
          resize:                        sizes[array] <= in[sizeBits-1:0];
          add, subtract, orOp, xorOp, andOp: out <= opResult;
          addAfter, subAfter:            out <= element;  // value before the update
          default: ;
        endcase
      end
    end
  end

  // every path that grows a size checks it against arrayLength first
  for (genvar g = 0; g < arrayCount; g++) begin : sizeCheck
    sizeBound: assert property (
      @(posedge clock) disable iff (reset) sizes[g] <= sizeBits'(arrayLength)
    );
  end

endmodule

// File: hdl/arrayHeap.sv
/*
  Top of the array heap. One action per clock on the loose inputs,
  out and error follow one cycle later with no handshake.
*/
`timescale 1ns/1ps

module arrayHeap import heapPkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  heapAction_t          action,          // sampled every edge
  input  logic [arrayBits-1:0] array,
  input  logic [indexBits-1:0] index,
  input  logic [dataBits-1:0]  in,
  output logic [dataBits-1:0]  out,
  output heapError_t           error
);

  // allocator to store
  logic                 arrayAllocated;
  logic                 grant;
  logic [arrayBits-1:0] grantArray;
  heapError_t           allocError;

  arrayAllocator allocator (
    .clock          (clock),
    .reset          (reset),
    .action         (action),
    .array          (array),
    .arrayAllocated (arrayAllocated),
    .grant          (grant),
    .grantArray     (grantArray),
    .allocError     (allocError)
  );

  arrayStore store (
    .clock          (clock),
    .reset          (reset),
    .action         (action),
    .array          (array),
    .index          (index),
    .in             (in),
    .arrayAllocated (arrayAllocated),
    .grant          (grant),
    .grantArray     (grantArray),
    .allocError     (allocError),
    .out            (out),
    .error          (error)
  );

endmodule

// File: testbench/arrayHeapTb.sv
/*
  Testbench for the array heap. Replays the directed cases of
  testbench/heapCases.txt, then runs seeded random element operations
  on one full array and checks them against a small model.
*/
`timescale 1ns/1ps

module arrayHeapTb import heapPkg::*; ();

  localparam int watchdogCycles = 2000;           // far above the real run length
  localparam int randomOps      = 60;
  localparam int randomArray    = 5;              // allocated near the end of the case file

  logic                 clock;
  logic                 reset;
  heapAction_t          action;
  logic [arrayBits-1:0] array;
  logic [indexBits-1:0] index;
  logic [dataBits-1:0]  in;
  logic [dataBits-1:0]  out;
  heapError_t           error;

  int                   cycleCount = 0;           // rising edges seen
  logic [31:0]          rngState;
  logic [dataBits-1:0]  model [arrayLength];      // expected contents of randomArray

  arrayHeap DUT (
    .clock  (clock),
    .reset  (reset),
    .action (action),
    .array  (array),
    .index  (index),
    .in     (in),
    .out    (out),
    .error  (error)
  );

  // clock and watchdog --------------------
  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;                    // 10 ns period
  end

  always @(posedge clock) cycleCount <= cycleCount + 1;

  initial begin
    for (int t = 0; t < watchdogCycles; t++) begin
      #10;
    end
    failRun("watchdog expired before the run finished");
  end

  // helpers --------------------
  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [dataBits-1:0] expected,
                       input logic [dataBits-1:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // ends on a falling edge, outputs settled
  task automatic waitCycles(input int count);
    int startCycle;
    int waited;
    startCycle = cycleCount;
    waited     = 0;
    while (cycleCount - startCycle < count) begin
      @(negedge clock);
      waited++;
      if (waited > count + 2) failRun("clock stopped advancing");
    end
  endtask

  // one action for one cycle, called on a falling edge
  task automatic applyAction(input heapAction_t act, input int arr, input int idx,
                             input logic [dataBits-1:0] data);
    action = act;
    array  = arr[arrayBits-1:0];
    index  = idx[indexBits-1:0];
    in     = data;
    waitCycles(1);
    action = idle;                                // overwritten by the next call
  endtask

  task automatic expectResponse(input string name, input logic [dataBits-1:0] expOut,
                                input heapError_t expErr);
    check({name, ".out"}, expOut, out);
    check({name, ".error"}, dataBits'(expErr), dataBits'(error));
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic bit parseAction(input string text, output heapAction_t act);
    parseAction = 1'b1;
    case (text)
      "idle":     act = idle;
      "write":    act = write;
      "read":     act = read;
      "size":     act = size;
      "inc":      act = inc;
      "dec":      act = dec;
      "push":     act = push;
      "pop":      act = pop;
      "resize":   act = resize;
      "alloc":    act = alloc;
      "free":     act = free;
      "add":      act = add;
      "addAfter": act = addAfter;
      "subtract": act = subtract;
      "subAfter": act = subAfter;
      "orOp":     act = orOp;
      "xorOp":    act = xorOp;
      "andOp":    act = andOp;
      default: begin
        act         = idle;
        parseAction = 1'b0;                       // unknown opcode name
      end
    endcase
  endfunction

  function automatic bit parseError(input string text, output heapError_t err);
    parseError = 1'b1;
    case (text)
      "none":         err = none;
      "notAllocated": err = notAllocated;
      "outOfBounds":  err = outOfBounds;
      "full":         err = full;
      "empty":        err = empty;
      "tooLarge":     err = tooLarge;
      "outOfMemory":  err = outOfMemory;
      default: begin
        err        = none;
        parseError = 1'b0;
      end
    endcase
  endfunction

  // directed cases --------------------
  task automatic replayCases();
    int                  fd;
    int                  fields;
    int                  lineNo;
    int                  applied;
    int                  arr;
    int                  idx;
    string               line;
    string               name;
    string               actName;
    string               errName;
    logic [dataBits-1:0] data;
    logic [dataBits-1:0] expOut;
    heapAction_t         act;
    heapError_t          expErr;
    fd = $fopen("testbench/heapCases.txt", "r");
    if (fd == 0) failRun("cannot open testbench/heapCases.txt");
    lineNo  = 0;
    applied = 0;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      lineNo++;
      if (line.len() < 2 || line.substr(0, 0) == "#") continue;  // blank or comment
      fields = $sscanf(line, "%s %s %d %d %h %h %s",
                       name, actName, arr, idx, data, expOut, errName);
      if (fields != 7) failRun($sformatf("malformed case line %0d", lineNo));
      if (!parseAction(actName, act)) failRun($sformatf("bad action on line %0d", lineNo));
      if (!parseError(errName, expErr)) failRun($sformatf("bad status on line %0d", lineNo));
      applyAction(act, arr, idx, data);
      expectResponse(name, expOut, expErr);
      applied++;
    end
    $fclose(fd);
    if (applied == 0) failRun("case file held no cases");
  endtask

  // random element operations --------------------
  task automatic randomPhase();
    heapAction_t         ops [8];
    heapAction_t         op;
    logic [dataBits-1:0] operand;
    logic [dataBits-1:0] oldValue;
    logic [dataBits-1:0] newValue;
    logic [dataBits-1:0] expOut;
    int                  idx;
    ops = '{add, addAfter, subtract, subAfter, orOp, xorOp, andOp, read};
    for (int i = 0; i < arrayLength; i++) begin   // fill, size grows to arrayLength
      rngState = xorshift(rngState);
      model[i] = rngState[dataBits-1:0];
      applyAction(write, randomArray, i, model[i]);
      expectResponse($sformatf("fill%0d", i), model[i], none);
    end
    for (int n = 0; n < randomOps; n++) begin
      rngState = xorshift(rngState);
      op       = ops[rngState[2:0]];
      idx      = int'(rngState[5:3]);
      operand  = rngState[31:16];
      oldValue = model[idx];
      case (op)
        add, addAfter:      newValue = oldValue + operand;  // 16-bit wrap
        subtract, subAfter: newValue = oldValue - operand;
        orOp:               newValue = oldValue | operand;
        xorOp:              newValue = oldValue ^ operand;
        andOp:              newValue = oldValue & operand;
        default:            newValue = oldValue;             // plain read
      endcase
      expOut     = (op == addAfter || op == subAfter) ? oldValue : newValue;
      model[idx] = newValue;
      applyAction(op, randomArray, idx, operand);
      expectResponse($sformatf("random%0d", n), expOut, none);
    end
    for (int i = 0; i < arrayLength; i++) begin   // final contents
      applyAction(read, randomArray, i, '0);
      expectResponse($sformatf("readback%0d", i), model[i], none);
    end
  endtask

  // main sequence --------------------
  initial begin
    action   = idle;
    array    = '0;
    index    = '0;
    in       = '0;
    reset    = 1'b1;
    rngState = 32'd57;
    waitCycles(4);                                // reset held 4 cycles
    reset = 1'b0;
    expectResponse("afterReset", '0, none);
    replayCases();
    randomPhase();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: testbench/heapCases.txt
# name action array index in(hex) expectedOut(hex) expectedError
# one action per line, out and error checked one clock later
alloc0 alloc 0 0 0000 0000 none
alloc1 alloc 0 0 0000 0001 none
alloc2 alloc 0 0 0000 0002 none
free1 free 1 0 0000 0002 none
free2 free 2 0 0000 0002 none
reuse2 alloc 0 0 0000 0002 none
reuse1 alloc 0 0 0000 0001 none
freeNever free 3 0 0000 0001 notAllocated
freeOnce free 1 0 0000 0001 none
freeTwice free 1 0 0000 0001 notAllocated
writeFreed write 1 0 0005 0001 notAllocated
realloc1 alloc 0 0 0000 0001 none
fresh3 alloc 0 0 0000 0003 none
# write, read, size and resize on array 0
write5 write 0 5 1234 1234 none
sizeAfterWrite size 0 0 0000 0006 none
read5 read 0 5 0000 1234 none
read6 read 0 6 0000 1234 outOfBounds
addPastEnd add 0 6 0001 1234 outOfBounds
resize9 resize 0 0 0009 1234 tooLarge
resize8 resize 0 0 0008 1234 none
size8 size 0 0 0000 0008 none
# push, pop, inc and dec on array 2
push1 push 2 0 0011 0008 none
push2 push 2 0 0022 0008 none
push3 push 2 0 0033 0008 none
push4 push 2 0 0044 0008 none
push5 push 2 0 0055 0008 none
push6 push 2 0 0066 0008 none
push7 push 2 0 0077 0008 none
push8 push 2 0 0088 0008 none
pushFull push 2 0 0099 0008 full
incFull inc 2 0 0000 0008 full
pop8 pop 2 0 0000 0088 none
pop7 pop 2 0 0000 0077 none
pop6 pop 2 0 0000 0066 none
pop5 pop 2 0 0000 0055 none
pop4 pop 2 0 0000 0044 none
pop3 pop 2 0 0000 0033 none
pop2 pop 2 0 0000 0022 none
pop1 pop 2 0 0000 0011 none
popEmpty pop 2 0 0000 0011 empty
decEmpty dec 2 0 0000 0011 empty
incOne inc 2 0 0000 0011 none
sizeOne size 2 0 0000 0001 none
decOne dec 2 0 0000 0001 none
# element arithmetic on array 3
writeBase write 3 0 fff0 fff0 none
addWrap add 3 0 0020 0010 none
readAdd read 3 0 0000 0010 none
addAfter5 addAfter 3 0 0005 0010 none
subWrap subtract 3 0 0020 fff5 none
subAfter5 subAfter 3 0 0005 fff5 none
orLow orOp 3 0 000f ffff none
xorMid xorOp 3 0 00f0 ff0f none
andMask andOp 3 0 0ff0 0f00 none
readFinal read 3 0 0000 0f00 none
# remaining arrays, then none left
alloc4 alloc 0 0 0000 0004 none
alloc5 alloc 0 0 0000 0005 none
alloc6 alloc 0 0 0000 0006 none
alloc7 alloc 0 0 0000 0007 none
allocNinth alloc 0 0 0000 0007 outOfMemory

// File: project.f
hdl/heapPkg.sv
hdl/arrayAllocator.sv
hdl/arrayStore.sv
hdl/arrayHeap.sv
testbench/arrayHeapTb.sv

// File: Makefile
VERILATOR   = verilator
TOP         = arrayHeapTb
FILELIST    = project.f
BUILD_DIR   = obj_dir
BUILD_FLAGS = --binary --timing --assert -Wno-fatal
LINT_FLAGS  = --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
